/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = sram_bridge_tb
FILELIST   = project.f
OBJ_DIR    = obj_dir
PASS_MSG   = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* logic/bridge_pkg.sv */
package bridge_pkg;

   // ----------------------------------------
   // data widths
   // ----------------------------------------

   typedef logic [31:0] word_t;   // host side word
   typedef logic [7:0]  byte_t;   // stream / port B byte

   // byte lane inside a word
   // lane 0 is bits 7:0, address ends in 00 (little endian)
   typedef logic [1:0]  lane_t;

   // ----------------------------------------
   // dma engine states
   // ----------------------------------------

   typedef enum logic [1:0] {
      IDLE,    // waiting for a command
      READ,    // sram -> outbound stream
      WRITE    // inbound stream -> sram
   } dma_state_e;

endpackage

/* logic/byte_dma.sv */
module byte_dma #(
   parameter int SBITS      = 10,
   parameter int LEN_BITS   = 8,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                 a_clk_i,
   input  logic                 rst_i,

   // command channel
   input  logic                 cmd_valid_i,
   output logic                 cmd_ready_o,
   input  logic                 cmd_write_i,
   input  logic [SBITS+1:0]     cmd_addr_i,    // byte address
   input  logic [LEN_BITS-1:0]  cmd_len_i,     // byte count, 0 = nothing

   // outbound bytes
   output logic                 rd_valid_o,
   input  logic                 rd_ready_i,
   output bridge_pkg::byte_t    rd_data_o,

   // inbound bytes
   input  logic                 wr_valid_i,
   output logic                 wr_ready_o,
   input  bridge_pkg::byte_t    wr_data_i,

   output logic                 done_o,        // one-cycle pulse

   wb_byte_if.master            bus
);

   localparam int CW = $clog2(FIFO_DEPTH) + 1;

   bridge_pkg::dma_state_e  state_q;
   logic [SBITS-1:0]        word_q;            // next word address
   bridge_pkg::lane_t       lane_q;            // next lane
   logic [LEN_BITS-1:0]     issue_q;           // bytes left to strobe
   logic [LEN_BITS-1:0]     finish_q;          // bytes left to complete
   logic [CW-1:0]           inflight_q;        // reads strobed, not yet acked
   logic                    done_q;

   logic                    rd_stb;
   logic                    wr_stb;
   logic                    bus_stb;
   logic                    rd_ack;
   logic                    fifo_pop;
   logic                    fifo_empty;
   logic                    fifo_full;
   logic [CW-1:0]           fifo_count;
   logic [CW:0]             reserved;          // credits taken from the fifo

   // ----------------------------------------
   // strobe generation
   // ----------------------------------------

   assign reserved = {1'b0, inflight_q} + {1'b0, fifo_count};

   // read only while every byte in flight is sure of a fifo slot
   assign rd_stb = (state_q == bridge_pkg::READ) && (issue_q != '0)
                   && (reserved < (CW+1)'(FIFO_DEPTH));

   assign wr_ready_o = (state_q == bridge_pkg::WRITE) && (issue_q != '0);
   assign wr_stb     = wr_ready_o && wr_valid_i;    // byte goes out this cycle
   assign bus_stb    = rd_stb || wr_stb;
   assign rd_ack     = bus.ack && (state_q == bridge_pkg::READ);

   assign bus.cyc   = (state_q != bridge_pkg::IDLE);  // held for the command
   assign bus.stb   = bus_stb;
   assign bus.we    = (state_q == bridge_pkg::WRITE);
   assign bus.adr   = {word_q, lane_q};
   assign bus.dat_w = wr_data_i;

   assign cmd_ready_o = (state_q == bridge_pkg::IDLE);
   assign done_o      = done_q;

   // ----------------------------------------
   // state machine and counters
   // ----------------------------------------

   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         state_q    <= bridge_pkg::IDLE;
         word_q     <= '0;
         lane_q     <= '0;
         issue_q    <= '0;
         finish_q   <= '0;
         inflight_q <= '0;
         done_q     <= 1'b0;
      end else begin
         done_q     <= 1'b0;
         inflight_q <= inflight_q + CW'(rd_stb) - CW'(rd_ack);

         if (bus_stb) begin
            issue_q        <= issue_q - 1'b1;
            {word_q, lane_q} <= {word_q, lane_q} + 1'b1;   // carries into word
         end

         case (state_q)
            bridge_pkg::IDLE: begin
               if (cmd_valid_i) begin
                  {word_q, lane_q} <= cmd_addr_i;
                  issue_q          <= cmd_len_i;
                  finish_q         <= cmd_len_i;
                  if (cmd_len_i == '0)
                     done_q <= 1'b1;                       // empty command
                  else if (cmd_write_i)
                     state_q <= bridge_pkg::WRITE;
                  else
                     state_q <= bridge_pkg::READ;
               end
            end
            bridge_pkg::READ: begin
               if (fifo_pop) begin                         // finished when consumed
                  finish_q <= finish_q - 1'b1;
                  if (finish_q == LEN_BITS'(1)) begin
                     done_q  <= 1'b1;
                     state_q <= bridge_pkg::IDLE;
                  end
               end
            end
            bridge_pkg::WRITE: begin
               if (bus.ack) begin                          // finished when acked
                  finish_q <= finish_q - 1'b1;
                  if (finish_q == LEN_BITS'(1)) begin
                     done_q  <= 1'b1;
                     state_q <= bridge_pkg::IDLE;
                  end
               end
            end
            default: state_q <= bridge_pkg::IDLE;
         endcase
      end
   end

   // ----------------------------------------
   // read data buffer
   // ----------------------------------------

   assign fifo_pop   = rd_valid_o && rd_ready_i;
   assign rd_valid_o = !fifo_empty;

   byte_fifo #(
      .DEPTH       (FIFO_DEPTH)
   ) u_rd_fifo (
      .a_clk_i     (a_clk_i),
      .rst_i       (rst_i),
      .push_i      (rd_ack),          // acked data cannot be stalled
      .push_data_i (bus.dat_r),
      .pop_i       (fifo_pop),
      .pop_data_o  (rd_data_o),
      .empty_o     (fifo_empty),
      .full_o      (fifo_full),
      .count_o     (fifo_count)
   );

   // credits taken never exceed the fifo slots
   credit_bound: assert property (@(posedge a_clk_i) disable iff (rst_i)
      reserved <= (CW+1)'(FIFO_DEPTH));

   // an acked byte always finds a free slot
   no_fifo_overflow: assert property (@(posedge a_clk_i) disable iff (rst_i)
      rd_ack |-> !fifo_full);

endmodule

/* logic/byte_fifo.sv */
module byte_fifo #(
   parameter int DEPTH = 4                         // power of two
) (
   input  logic                     a_clk_i,
   input  logic                     rst_i,
   input  logic                     push_i,
   input  bridge_pkg::byte_t        push_data_i,
   input  logic                     pop_i,
   output bridge_pkg::byte_t        pop_data_o,    // head, valid when !empty_o
   output logic                     empty_o,
   output logic                     full_o,
   output logic [$clog2(DEPTH):0]   count_o
);

   localparam int AW = $clog2(DEPTH);

   bridge_pkg::byte_t   mem [DEPTH];
   logic [AW-1:0]       wr_ptr_q;                  // wraps at DEPTH
   logic [AW-1:0]       rd_ptr_q;
   logic [AW:0]         count_q;                   // occupancy

   // storage, no reset
   always_ff @(posedge a_clk_i) begin
      if (push_i)
         mem[wr_ptr_q] <= push_data_i;
   end

   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_q + (AW+1)'(push_i) - (AW+1)'(pop_i);
      end
   end

   assign pop_data_o = mem[rd_ptr_q];
   assign empty_o    = (count_q == '0);
   assign full_o     = (count_q == (AW+1)'(DEPTH));
   assign count_o    = count_q;

   // callers must respect the flags
   no_push_when_full: assert property (@(posedge a_clk_i) disable iff (rst_i)
      push_i |-> !full_o);

   no_pop_when_empty: assert property (@(posedge a_clk_i) disable iff (rst_i)
      pop_i |-> !empty_o);

endmodule

/* logic/sram_bridge_top.sv */
module sram_bridge_top #(
   parameter int SBITS      = 10,     // word address width
   parameter int LEN_BITS   = 8,      // command byte count width
   parameter int FIFO_DEPTH = 4       // read buffer entries
) (
   input  logic                 a_clk_i,
   input  logic                 rst_i,

   // host port, 32-bit pipelined
   input  logic                 a_cyc_i,
   input  logic                 a_stb_i,
   input  logic                 a_we_i,
   input  logic [SBITS-1:0]     a_adr_i,
   input  bridge_pkg::word_t    a_dat_i,
   output logic                 a_ack_o,
   output bridge_pkg::word_t    a_dat_o,

   // dma command
   input  logic                 cmd_valid_i,
   output logic                 cmd_ready_o,
   input  logic                 cmd_write_i,
   input  logic [SBITS+1:0]     cmd_addr_i,
   input  logic [LEN_BITS-1:0]  cmd_len_i,

   // byte streams
   output logic                 rd_valid_o,
   input  logic                 rd_ready_i,
   output bridge_pkg::byte_t    rd_data_o,
   input  logic                 wr_valid_i,
   output logic                 wr_ready_o,
   input  bridge_pkg::byte_t    wr_data_i,

   output logic                 done_o
);

   // dma <-> sram byte bus
   wb_byte_if #(.ABITS(SBITS + 2)) byte_bus ();

   wb_sram_dual_port #(
      .SBITS   (SBITS)
   ) u_sram (
      .a_clk_i (a_clk_i),
      .rst_i   (rst_i),
      .a_cyc_i (a_cyc_i),
      .a_stb_i (a_stb_i),
      .a_we_i  (a_we_i),
      .a_adr_i (a_adr_i),
      .a_dat_i (a_dat_i),
      .a_ack_o (a_ack_o),
      .a_dat_o (a_dat_o),
      .b       (byte_bus.slave)
   );

   byte_dma #(
      .SBITS       (SBITS),
      .LEN_BITS    (LEN_BITS),
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) u_dma (
      .a_clk_i     (a_clk_i),
      .rst_i       (rst_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_write_i (cmd_write_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_len_i   (cmd_len_i),
      .rd_valid_o  (rd_valid_o),
      .rd_ready_i  (rd_ready_i),
      .rd_data_o   (rd_data_o),
      .wr_valid_i  (wr_valid_i),
      .wr_ready_o  (wr_ready_o),
      .wr_data_i   (wr_data_i),
      .done_o      (done_o),
      .bus         (byte_bus.master)
   );

endmodule

/* logic/wb_byte_if.sv */
// 8-bit pipelined bus, dma to sram port B
// one transfer per cycle with cyc && stb, ack exactly one cycle later
interface wb_byte_if #(
   parameter int ABITS = 12           // byte address width
);

   logic                    cyc;      // bus cycle active
   logic                    stb;      // transfer strobe
   logic                    we;       // 1 = write
   logic [ABITS-1:0]        adr;      // byte address
   bridge_pkg::byte_t       dat_w;    // write data
   logic                    ack;      // one cycle after stb
   bridge_pkg::byte_t       dat_r;    // read data, valid with ack

   modport master (
      output cyc,
      output stb,
      output we,
      output adr,
      output dat_w,
      input  ack,
      input  dat_r
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  adr,
      input  dat_w,
      output ack,
      output dat_r
   );

endinterface

/* logic/wb_sram_dual_port.sv */
module wb_sram_dual_port #(
   parameter int SBITS = 10               // word address width
) (
   input  logic                 a_clk_i,
   input  logic                 rst_i,

   // 32-bit host port
   input  logic                 a_cyc_i,
   input  logic                 a_stb_i,
   input  logic                 a_we_i,
   input  logic [SBITS-1:0]     a_adr_i,   // word address
   input  bridge_pkg::word_t    a_dat_i,
   output logic                 a_ack_o,
   output bridge_pkg::word_t    a_dat_o,

   // 8-bit port, byte addressed
   wb_byte_if.slave             b
);

   localparam int SIZE = 1 << SBITS;

   logic                a_stb;
   logic                b_stb;
   logic [SBITS-1:0]    b_word;            // upper bits of byte address
   bridge_pkg::lane_t   b_lane;            // bank select

   bridge_pkg::byte_t   a_rd_q [4];        // per-lane read data, port A
   bridge_pkg::byte_t   b_rd_q [4];        // per-lane read data, port B
   bridge_pkg::lane_t   b_lane_q;          // lane of the pending B read

   assign a_stb  = a_cyc_i && a_stb_i;
   assign b_stb  = b.cyc && b.stb;
   assign b_word = b.adr[SBITS+1:2];
   assign b_lane = b.adr[1:0];

   // ----------------------------------------
   // four byte banks, one per lane
   // ----------------------------------------

   for (genvar g = 0; g < 4; g++) begin : g_lane
      bridge_pkg::byte_t bank [SIZE] = '{default: '0};   // cleared in sim

      always_ff @(posedge a_clk_i) begin
         if (a_stb) begin
            a_rd_q[g] <= bank[a_adr_i];                  // old content
            if (a_we_i)
               bank[a_adr_i] <= a_dat_i[8*g +: 8];
         end
         if (b_stb) begin
            b_rd_q[g] <= bank[b_word];
            // issued after port A, so B wins its own lane on a collision
            if (b.we && (b_lane == bridge_pkg::lane_t'(g)))
               bank[b_word] <= b.dat_w;
         end
      end
   end

   // ----------------------------------------
   // acks and read muxing
   // ----------------------------------------

   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         a_ack_o <= 1'b0;
         b.ack   <= 1'b0;
      end else begin
         a_ack_o <= a_stb;                // fixed one-cycle ack
         b.ack   <= b_stb;
      end
   end

   always_ff @(posedge a_clk_i) begin
      if (b_stb)
         b_lane_q <= b_lane;              // picks the byte next cycle
   end

   assign a_dat_o = {a_rd_q[3], a_rd_q[2], a_rd_q[1], a_rd_q[0]};
   assign b.dat_r = b_rd_q[b_lane_q];

   // ack only ever answers a strobe of the cycle before
   a_ack_follows_stb: assert property (@(posedge a_clk_i) disable iff (rst_i)
      a_ack_o |-> $past(a_cyc_i && a_stb_i));

   b_ack_follows_stb: assert property (@(posedge a_clk_i) disable iff (rst_i)
      b.ack |-> $past(b.cyc && b.stb));

   // the dma must present a resolved address
   b_adr_known: assert property (@(posedge a_clk_i) disable iff (rst_i)
      (b.cyc && b.stb) |-> !$isunknown(b.adr));

endmodule

/* project.f */
logic/bridge_pkg.sv
logic/wb_byte_if.sv
logic/wb_sram_dual_port.sv
logic/byte_fifo.sv
logic/byte_dma.sv
logic/sram_bridge_top.sv
verification/sram_bridge_tb.sv

/* verification/sram_bridge_tb.sv */
module sram_bridge_tb;

   localparam int SBITS    = 10;
   localparam int LEN_BITS = 8;
   localparam int BYTES    = 4 << SBITS;    // sram size in bytes
   localparam int TIMEOUT  = 2000;          // cycles per wait

   localparam logic [1:0] HOST_WR = 2'd0;
   localparam logic [1:0] HOST_RD = 2'd1;
   localparam logic [1:0] DMA_RD  = 2'd2;
   localparam logic [1:0] DMA_WR  = 2'd3;

   typedef struct packed {
      logic [1:0]          kind;
      logic [SBITS+1:0]    addr;    // word address for host, byte address for dma
      logic [LEN_BITS-1:0] len;     // dma byte count
      bridge_pkg::word_t   data;    // host write data
      logic                gaps;    // random stream stalls
   } step_t;

   localparam int NSTEPS = 15;

   step_t steps [NSTEPS] = '{
      '{HOST_WR, 12'd4,   8'd0,   32'h4433_2211, 1'b0},
      '{HOST_WR, 12'd5,   8'd0,   32'h8877_6655, 1'b0},
      '{HOST_WR, 12'd6,   8'd0,   32'hccbb_aa99, 1'b0},
      '{HOST_RD, 12'd5,   8'd0,   32'h0,         1'b0},
      '{DMA_RD,  12'd17,  8'd9,   32'h0,         1'b0},   // unaligned start
      '{DMA_WR,  12'd22,  8'd5,   32'h0,         1'b0},   // partial words
      '{HOST_RD, 12'd5,   8'd0,   32'h0,         1'b0},
      '{HOST_RD, 12'd6,   8'd0,   32'h0,         1'b0},
      '{HOST_RD, 12'd4,   8'd0,   32'h0,         1'b0},
      '{DMA_RD,  12'd16,  8'd12,  32'h0,         1'b0},
      '{DMA_WR,  12'd128, 8'd64,  32'h0,         1'b1},   // wr_valid_i gaps
      '{DMA_RD,  12'd129, 8'd60,  32'h0,         1'b1},   // rd_ready_i stalls
      '{DMA_RD,  12'd0,   8'd0,   32'h0,         1'b0},   // empty command
      '{HOST_RD, 12'd33,  8'd0,   32'h0,         1'b0},
      '{DMA_RD,  12'd126, 8'd200, 32'h0,         1'b1}    // long read
   };

   logic                  a_clk_i;
   logic                  rst_i;
   logic                  a_cyc_i;
   logic                  a_stb_i;
   logic                  a_we_i;
   logic [SBITS-1:0]      a_adr_i;
   bridge_pkg::word_t     a_dat_i;
   logic                  a_ack_o;
   bridge_pkg::word_t     a_dat_o;
   logic                  cmd_valid_i;
   logic                  cmd_ready_o;
   logic                  cmd_write_i;
   logic [SBITS+1:0]      cmd_addr_i;
   logic [LEN_BITS-1:0]   cmd_len_i;
   logic                  rd_valid_o;
   logic                  rd_ready_i;
   bridge_pkg::byte_t     rd_data_o;
   logic                  wr_valid_i;
   logic                  wr_ready_o;
   bridge_pkg::byte_t     wr_data_i;
   logic                  done_o;

   bridge_pkg::byte_t     shadow [BYTES];   // byte addressed reference model
   int                    mismatches = 0;
   int                    timeouts   = 0;

   sram_bridge_top #(
      .SBITS      (SBITS),
      .LEN_BITS   (LEN_BITS),
      .FIFO_DEPTH (4)
   ) DUT (.*);

   initial begin
      a_clk_i = 1'b0;
      forever #4 a_clk_i = ~a_clk_i;      // period 8
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------

   task automatic flag_mismatch(input string msg);
      mismatches++;
      $display("MISMATCH at %0t: %s", $time, msg);
   endtask

   task automatic flag_timeout(input string msg);
      timeouts++;
      $display("timeout at %0t: %s", $time, msg);
   endtask

   // lane 0 is the lowest byte address
   function automatic bridge_pkg::word_t shadow_word(input int wadr);
      return {shadow[4*wadr+3], shadow[4*wadr+2], shadow[4*wadr+1], shadow[4*wadr]};
   endfunction

   // single port A transfer, ack must land exactly one cycle after the strobe
   task automatic host_access(input logic we, input logic [SBITS-1:0] adr,
                              input bridge_pkg::word_t wdata,
                              output bridge_pkg::word_t rdata);
      @(posedge a_clk_i);
      a_cyc_i <= 1'b1;
      a_stb_i <= 1'b1;
      a_we_i  <= we;
      a_adr_i <= adr;
      a_dat_i <= wdata;
      @(negedge a_clk_i);
      assert (!a_ack_o) else flag_mismatch("a_ack_o high before the strobe was taken");
      @(posedge a_clk_i);
      a_cyc_i <= 1'b0;
      a_stb_i <= 1'b0;
      a_we_i  <= 1'b0;
      @(negedge a_clk_i);
      assert (a_ack_o) else flag_mismatch("no a_ack_o one cycle after the strobe");
      rdata = a_dat_o;                    // registered, stable at negedge
      @(negedge a_clk_i);
      assert (!a_ack_o) else flag_mismatch("a_ack_o held for more than one cycle");
   endtask

   // returns just after the accepting edge
   task automatic issue_cmd(input logic wr, input logic [SBITS+1:0] adr,
                            input logic [LEN_BITS-1:0] len);
      int n;
      n = 0;
      @(posedge a_clk_i);
      cmd_valid_i <= 1'b1;
      cmd_write_i <= wr;
      cmd_addr_i  <= adr;
      cmd_len_i   <= len;
      @(negedge a_clk_i);
      while (!cmd_ready_o && n < TIMEOUT) begin
         @(negedge a_clk_i);
         n++;
      end
      assert (cmd_ready_o) else flag_timeout("the DMA never accepted the command");
      @(posedge a_clk_i);
      cmd_valid_i <= 1'b0;
   endtask

   task automatic dma_read(input logic [SBITS+1:0] adr, input logic [LEN_BITS-1:0] len,
                           input logic gaps);
      bridge_pkg::byte_t got [$];
      bridge_pkg::byte_t exp;
      int                n;
      logic              seen_done;
      n         = 0;
      seen_done = 1'b0;
      issue_cmd(1'b0, adr, len);
      rd_ready_i <= !gaps || ($urandom_range(3) != 0);
      while (!seen_done && n < TIMEOUT) begin
         @(negedge a_clk_i);
         if (rd_valid_o && rd_ready_i)
            got.push_back(rd_data_o);     // beat taken at the next edge
         seen_done = done_o;
         @(posedge a_clk_i);
         rd_ready_i <= !gaps || ($urandom_range(3) != 0);
         n++;
      end
      rd_ready_i <= 1'b0;
      assert (seen_done) else flag_timeout("done_o never pulsed after the DMA read");
      @(negedge a_clk_i);
      assert (!done_o) else flag_mismatch("done_o longer than one cycle after a read");
      assert (!rd_valid_o) else flag_mismatch("rd_valid_o still high after done_o");
      assert (got.size() == int'(len))
         else flag_mismatch($sformatf("read gave %0d bytes, expected %0d", got.size(), len));
      for (int i = 0; i < got.size() && i < int'(len); i++) begin
         exp = shadow[(int'(adr) + i) % BYTES];
         assert (got[i] == exp)
            else flag_mismatch($sformatf("read byte %0d at %0d: got %h expected %h",
                                         i, int'(adr) + i, got[i], exp));
      end
   endtask

   task automatic dma_write(input logic [SBITS+1:0] adr, input logic [LEN_BITS-1:0] len,
                            input logic gaps);
      bridge_pkg::byte_t bytes [$];
      int                n;
      int                idx;
      logic              seen_done;
      logic              beat;
      n         = 0;
      idx       = 0;
      seen_done = 1'b0;
      for (int i = 0; i < int'(len); i++)
         bytes.push_back(8'($urandom));
      issue_cmd(1'b1, adr, len);
      wr_valid_i <= (len != '0) && (!gaps || ($urandom_range(3) != 0));
      wr_data_i  <= (len != '0) ? bytes[0] : 8'h00;
      while (!seen_done && n < TIMEOUT) begin
         @(negedge a_clk_i);
         beat      = wr_valid_i && wr_ready_o;
         seen_done = done_o;
         @(posedge a_clk_i);
         if (beat)
            idx++;
         wr_valid_i <= (idx < int'(len)) && (!gaps || ($urandom_range(3) != 0));
         wr_data_i  <= (idx < int'(len)) ? bytes[idx] : 8'h00;
         n++;
      end
      wr_valid_i <= 1'b0;
      assert (seen_done) else flag_timeout("done_o never pulsed after the DMA write");
      assert (idx == int'(len))
         else flag_mismatch($sformatf("write took %0d beats, expected %0d", idx, len));
      for (int i = 0; i < int'(len); i++)
         shadow[(int'(adr) + i) % BYTES] = bytes[i];
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   initial begin
      bridge_pkg::word_t rdata;
      void'($urandom(17708));
      foreach (shadow[i])
         shadow[i] = 8'h00;               // sram starts cleared
      rst_i       = 1'b1;
      a_cyc_i     = 1'b0;
      a_stb_i     = 1'b0;
      a_we_i      = 1'b0;
      a_adr_i     = '0;
      a_dat_i     = '0;
      cmd_valid_i = 1'b0;
      cmd_write_i = 1'b0;
      cmd_addr_i  = '0;
      cmd_len_i   = '0;
      rd_ready_i  = 1'b0;
      wr_valid_i  = 1'b0;
      wr_data_i   = '0;
      repeat (4) @(posedge a_clk_i);
      rst_i <= 1'b0;
      @(negedge a_clk_i);
      assert (!a_ack_o && !rd_valid_o && !wr_ready_o && !done_o && cmd_ready_o)
         else flag_mismatch("outputs not in their reset state");

      for (int s = 0; s < NSTEPS; s++) begin
         case (steps[s].kind)
            HOST_WR: begin
               host_access(1'b1, steps[s].addr[SBITS-1:0], steps[s].data, rdata);
               for (int l = 0; l < 4; l++)
                  shadow[4*int'(steps[s].addr) + l] = steps[s].data[8*l +: 8];
            end
            HOST_RD: begin
               host_access(1'b0, steps[s].addr[SBITS-1:0], '0, rdata);
               assert (rdata == shadow_word(int'(steps[s].addr)))
                  else flag_mismatch($sformatf("host read word %0d: got %h expected %h",
                     steps[s].addr, rdata, shadow_word(int'(steps[s].addr))));
            end
            DMA_RD:  dma_read(steps[s].addr, steps[s].len, steps[s].gaps);
            default: dma_write(steps[s].addr, steps[s].len, steps[s].gaps);
         endcase
      end

      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
